/* Makefile */
# Verilator build and regression for the dispatch stage
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, whatever the exit code of the simulation
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/dispatch_ctrl.sv */
// Issue control for one instruction per cycle; a busy source word carries its tag in the low bits
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl #(
    parameter int TAG_N = 8
  , parameter int ROB_N = 8
  , localparam int TAG_W = $clog2(TAG_N)
  , localparam int ROB_W = $clog2(ROB_N)
) (
    input  wire logic                              clk
  , input  wire logic                              rst
  // Instruction handshake
  , input  wire logic                              inst_vld
  , input  wire tomasulo_pkg::opcode_e             inst_op
  , input  wire tomasulo_pkg::reg_t                inst_wa
  , input  wire tomasulo_pkg::reg_t                inst_ra0
  , input  wire tomasulo_pkg::reg_t                inst_ra1
  , input  wire tomasulo_pkg::word_t               inst_imm
  , output logic                                   inst_adv
  // Resource state
  , input  wire logic [tomasulo_pkg::RS_N-1:0]     rs_full
  , input  wire logic                              tag_avail
  , input  wire logic [TAG_W-1:0]                  free_tag
  , input  wire logic                              rob_full
  , input  wire logic [ROB_W-1:0]                  alloc_robid
  // Register state lookup
  , input  wire logic [1:0]                        src_busy
  , input  wire logic [TAG_W-1:0]                  src_tag0
  , input  wire logic [TAG_W-1:0]                  src_tag1
  , input  wire tomasulo_pkg::word_t               src_data0
  , input  wire tomasulo_pkg::word_t               src_data1
  , input  wire logic                              wa_busy
  // CDB for bypass
  , input  wire logic                              cdb_vld
  , input  wire tomasulo_pkg::reg_t                cdb_wa
  , input  wire tomasulo_pkg::word_t               cdb_wdata
  // Allocation strobe to the free list, register state and ROB
  , output logic                                   dis_fire
  , output logic [tomasulo_pkg::RS_N-1:0]          dis_vld_r
  , output tomasulo_pkg::opcode_e                  dis_op_r
  , output tomasulo_pkg::reg_t                     dis_wa_r
  , output logic [TAG_W-1:0]                       dis_tag_r
  , output logic [ROB_W-1:0]                       dis_robid_r
  , output tomasulo_pkg::word_t                    dis_imm_r
  , output logic [1:0]                             dis_src_busy_r
  , output tomasulo_pkg::word_t                    dis_src0_r
  , output tomasulo_pkg::word_t                    dis_src1_r
);

  logic [tomasulo_pkg::RS_N-1:0] rs_sel;
  logic [tomasulo_pkg::WORD_W:0] opr0;
  logic [tomasulo_pkg::WORD_W:0] opr1;

  // Returns {busy, word}; a result on the CDB this cycle clears busy
  function automatic logic [tomasulo_pkg::WORD_W:0] form_opr(
      logic busy, tomasulo_pkg::reg_t ra, logic [TAG_W-1:0] tag, tomasulo_pkg::word_t data);
    if (busy && cdb_vld && cdb_wa == ra)
      return {1'b0, cdb_wdata};
    else if (busy)
      return {1'b1, tomasulo_pkg::word_t'(tag)};
    else
      return {1'b0, data};
  endfunction

  // Lowest non-full station of the unit class
  always_comb begin
    rs_sel = '0;
    case (tomasulo_pkg::unit_of(inst_op))
      tomasulo_pkg::UNIT_ARITH: begin
        if (!rs_full[0])
          rs_sel[0] = 1'b1;
        else if (!rs_full[1])
          rs_sel[1] = 1'b1;
      end
      tomasulo_pkg::UNIT_LOGIC: begin
        if (!rs_full[2])
          rs_sel[2] = 1'b1;
        else if (!rs_full[3])
          rs_sel[3] = 1'b1;
      end
      tomasulo_pkg::UNIT_MPY: begin
        rs_sel[4] = !rs_full[4];
      end
      default: rs_sel = '0;
    endcase
  end

  // Tag, ROB slot, station and a free destination are all needed
  assign dis_fire = inst_vld && tag_avail && !rob_full && !wa_busy && |rs_sel;
  assign inst_adv = dis_fire;

  assign opr0 = form_opr(src_busy[0], inst_ra0, src_tag0, src_data0);
  // ADDI takes no second register
  assign opr1 = tomasulo_pkg::uses_imm(inst_op) ? '0 :
                form_opr(src_busy[1], inst_ra1, src_tag1, src_data1);

  always_ff @(posedge clk) begin
    if (rst)
      dis_vld_r <= '0;
    else
      dis_vld_r <= dis_fire ? rs_sel : '0;
  end

  // Payload held between dispatches
  always_ff @(posedge clk) begin
    if (dis_fire) begin
      dis_op_r       <= inst_op;
      dis_wa_r       <= inst_wa;
      dis_tag_r      <= free_tag;
      dis_robid_r    <= alloc_robid;
      dis_imm_r      <= inst_imm;
      dis_src_busy_r <= {opr1[tomasulo_pkg::WORD_W], opr0[tomasulo_pkg::WORD_W]};
      dis_src0_r     <= opr0[tomasulo_pkg::WORD_W-1:0];
      dis_src1_r     <= opr1[tomasulo_pkg::WORD_W-1:0];
    end
  end

  // One station per dispatch
  a_dis_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(dis_vld_r));

endmodule

`default_nettype wire

/* design/reg_state.sv */
// Register values, busy bits and producer tags; relies on the WAW stall for one producer per register
`timescale 1ns/10ps
`default_nettype none

module reg_state #(
    parameter int TAG_N = 8
  , localparam int TAG_W = $clog2(TAG_N)
) (
    input  wire logic                 clk
  , input  wire logic                 rst
  // Dispatch read addresses
  , input  wire tomasulo_pkg::reg_t   ra0
  , input  wire tomasulo_pkg::reg_t   ra1
  // Dispatch marks its destination busy
  , input  wire logic                 set_busy
  , input  wire tomasulo_pkg::reg_t   set_wa
  , input  wire logic [TAG_W-1:0]     set_tag
  // CDB completion
  , input  wire logic                 cdb_vld
  , input  wire tomasulo_pkg::reg_t   cdb_wa
  , input  wire tomasulo_pkg::word_t  cdb_wdata
  , output logic [1:0]                src_busy
  , output logic [TAG_W-1:0]          src_tag0
  , output logic [TAG_W-1:0]          src_tag1
  , output tomasulo_pkg::word_t       src_data0
  , output tomasulo_pkg::word_t       src_data1
  , output logic                      wa_busy
);

  tomasulo_pkg::word_t           reg_val  [tomasulo_pkg::REG_N];
  logic [tomasulo_pkg::REG_N-1:0] reg_busy;
  logic [TAG_W-1:0]              reg_tag  [tomasulo_pkg::REG_N];

  // Plain reads, bypass is resolved in dispatch
  assign src_busy  = {reg_busy[ra1], reg_busy[ra0]};
  assign src_tag0  = reg_tag[ra0];
  assign src_tag1  = reg_tag[ra1];
  assign src_data0 = reg_val[ra0];
  assign src_data1 = reg_val[ra1];

  // Destination check for the WAW stall
  assign wa_busy = reg_busy[set_wa];

  // Values come up as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < tomasulo_pkg::REG_N; i++)
        reg_val[i] <= '0;
    end else if (cdb_vld) begin
      reg_val[cdb_wa] <= cdb_wdata;
    end
  end

  // Dispatch set is written last so it wins over a CDB clear
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_busy <= '0;
    end else begin
      if (cdb_vld)
        reg_busy[cdb_wa] <= 1'b0;
      if (set_busy)
        reg_busy[set_wa] <= 1'b1;
    end
  end

  // Tag only means something while busy
  always_ff @(posedge clk) begin
    if (set_busy)
      reg_tag[set_wa] <= set_tag;
  end

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
// In-order retire buffer of ROB_N >= 2 entries; no output back-pressure, completions must hit live entries
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_N = 8
  , localparam int ROB_W = $clog2(ROB_N)
  , localparam int CNT_W = $clog2(ROB_N + 1)
) (
    input  wire logic                 clk
  , input  wire logic                 rst
  // Allocate at the tail on dispatch
  , input  wire logic                 alloc
  , input  wire tomasulo_pkg::reg_t   alloc_wa
  // CDB completion by ROB index
  , input  wire logic                 cmpl_vld
  , input  wire logic [ROB_W-1:0]     cmpl_id
  , input  wire tomasulo_pkg::word_t  cmpl_data
  , output logic [ROB_W-1:0]          alloc_robid
  , output logic                      rob_full
  // Retire port
  , output logic                      out_vld_r
  , output tomasulo_pkg::reg_t        out_wa_r
  , output tomasulo_pkg::word_t       out_wdata_r
);

  logic [ROB_W-1:0]    head;
  logic [ROB_W-1:0]    tail;
  logic [CNT_W-1:0]    count;
  logic [ROB_N-1:0]    done;
  tomasulo_pkg::reg_t  ent_wa   [ROB_N];
  tomasulo_pkg::word_t ent_data [ROB_N];
  logic                retire;
  int                  cmpl_dist;

  // Wrap for any depth
  function automatic logic [ROB_W-1:0] ptr_inc(logic [ROB_W-1:0] p);
    return (p == ROB_W'(ROB_N - 1)) ? '0 : p + 1'b1;
  endfunction

  assign alloc_robid = tail;
  assign rob_full    = count == CNT_W'(ROB_N);

  // Head leaves once its result is in
  assign retire = count != '0 && done[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc)
        tail <= ptr_inc(tail);
      if (retire)
        head <= ptr_inc(head);
      if (alloc && !retire)
        count <= count + 1'b1;
      else if (!alloc && retire)
        count <= count - 1'b1;
    end
  end

  // Done bits restart on allocation, so only the count needs reset
  always_ff @(posedge clk) begin
    if (cmpl_vld)
      done[cmpl_id] <= 1'b1;
    if (alloc)
      done[tail] <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (alloc)
      ent_wa[tail] <= alloc_wa;
    if (cmpl_vld)
      ent_data[cmpl_id] <= cmpl_data;
  end

  always_ff @(posedge clk) begin
    if (rst)
      out_vld_r <= 1'b0;
    else
      out_vld_r <= retire;
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      out_wa_r    <= ent_wa[head];
      out_wdata_r <= ent_data[head];
    end
  end

  // Position of the completing entry behind the head
  always_comb begin
    cmpl_dist = int'(cmpl_id) - int'(head);
    if (cmpl_dist < 0)
      cmpl_dist = cmpl_dist + ROB_N;
  end

  // Dispatch checks rob_full before it allocates
  a_no_alloc_full : assert property (@(posedge clk) disable iff (rst) alloc |-> !rob_full);

  // The CDB only completes entries between head and tail
  a_cmpl_live : assert property (@(posedge clk) disable iff (rst)
    cmpl_vld |-> cmpl_dist < int'(count));

endmodule

`default_nettype wire

/* design/tag_free_list.sv */
// Tag pool of TAG_N entries; caller must not alloc without tag_avail or free an idle tag
`timescale 1ns/10ps
`default_nettype none

module tag_free_list #(
    parameter int TAG_N = 8
  , localparam int TAG_W = $clog2(TAG_N)
) (
    input  wire logic             clk
  , input  wire logic             rst
  // Take free_tag on this edge
  , input  wire logic             alloc
  // Return a tag from the CDB
  , input  wire logic             free_vld
  , input  wire logic [TAG_W-1:0] free_id
  , output logic      [TAG_W-1:0] free_tag
  , output logic                  tag_avail
);

  // One bit per tag, set while a producer owns it
  logic [TAG_N-1:0] in_use;

  // Lowest clear bit wins, so scan downwards
  always_comb begin
    free_tag = '0;
    for (int i = TAG_N - 1; i >= 0; i--) begin
      if (!in_use[i])
        free_tag = TAG_W'(i);
    end
  end

  assign tag_avail = ~&in_use;

  // Free and alloc never hit the same bit: alloc takes a clear one
  always_ff @(posedge clk) begin
    if (rst) begin
      in_use <= '0;
    end else begin
      if (free_vld)
        in_use[free_id] <= 1'b0;
      if (alloc)
        in_use[free_tag] <= 1'b1;
    end
  end

  // Dispatch only fires with a tag in hand
  a_alloc_avail : assert property (@(posedge clk) disable iff (rst) alloc |-> tag_avail);

  // CDB returns only tags that were handed out
  a_free_in_use : assert property (@(posedge clk) disable iff (rst)
    free_vld |-> in_use[free_id]);

endmodule

`default_nettype wire

/* design/tomasulo_dispatcher.sv */
// Dispatch stage top; cdb_vld is a one-cycle strobe and retire output has no back-pressure
`timescale 1ns/10ps
`default_nettype none

module tomasulo_dispatcher #(
    parameter int TAG_N = 8
  , parameter int ROB_N = 8
  , localparam int TAG_W = $clog2(TAG_N)
  , localparam int ROB_W = $clog2(ROB_N)
) (
    input  wire logic                          clk
  , input  wire logic                          rst
  // Instruction in
  , input  wire logic                          inst_vld
  , input  wire tomasulo_pkg::opcode_e         inst_op
  , input  wire tomasulo_pkg::reg_t            inst_wa
  , input  wire tomasulo_pkg::reg_t            inst_ra0
  , input  wire tomasulo_pkg::reg_t            inst_ra1
  , input  wire tomasulo_pkg::word_t           inst_imm
  , output logic                               inst_adv
  // Station occupancy
  , input  wire logic [tomasulo_pkg::RS_N-1:0] rs_full
  // CDB
  , input  wire logic                          cdb_vld
  , input  wire tomasulo_pkg::reg_t            cdb_wa
  , input  wire logic [TAG_W-1:0]              cdb_tag
  , input  wire logic [ROB_W-1:0]              cdb_robid
  , input  wire tomasulo_pkg::word_t           cdb_wdata
  // Dispatch out
  , output logic [tomasulo_pkg::RS_N-1:0]      dis_vld_r
  , output tomasulo_pkg::opcode_e              dis_op_r
  , output tomasulo_pkg::reg_t                 dis_wa_r
  , output logic [TAG_W-1:0]                   dis_tag_r
  , output logic [ROB_W-1:0]                   dis_robid_r
  , output tomasulo_pkg::word_t                dis_imm_r
  , output logic [1:0]                         dis_src_busy_r
  , output tomasulo_pkg::word_t                dis_src0_r
  , output tomasulo_pkg::word_t                dis_src1_r
  // Retire out
  , output logic                               out_vld_r
  , output tomasulo_pkg::reg_t                 out_wa_r
  , output tomasulo_pkg::word_t                out_wdata_r
);

  logic                dis_fire;
  logic [TAG_W-1:0]    free_tag;
  logic                tag_avail;
  logic [ROB_W-1:0]    alloc_robid;
  logic                rob_full;
  logic [1:0]          src_busy;
  logic [TAG_W-1:0]    src_tag0;
  logic [TAG_W-1:0]    src_tag1;
  tomasulo_pkg::word_t src_data0;
  tomasulo_pkg::word_t src_data1;
  logic                wa_busy;

  // CDB returns the producer's tag
  tag_free_list #(.TAG_N(TAG_N)) u_free_list (
      .clk       (clk)
    , .rst       (rst)
    , .alloc     (dis_fire)
    , .free_vld  (cdb_vld)
    , .free_id   (cdb_tag)
    , .free_tag  (free_tag)
    , .tag_avail (tag_avail)
  );

  // New producer of inst_wa is the tag being allocated
  reg_state #(.TAG_N(TAG_N)) u_reg_state (
      .clk       (clk)
    , .rst       (rst)
    , .ra0       (inst_ra0)
    , .ra1       (inst_ra1)
    , .set_busy  (dis_fire)
    , .set_wa    (inst_wa)
    , .set_tag   (free_tag)
    , .cdb_vld   (cdb_vld)
    , .cdb_wa    (cdb_wa)
    , .cdb_wdata (cdb_wdata)
    , .src_busy  (src_busy)
    , .src_tag0  (src_tag0)
    , .src_tag1  (src_tag1)
    , .src_data0 (src_data0)
    , .src_data1 (src_data1)
    , .wa_busy   (wa_busy)
  );

  dispatch_ctrl #(.TAG_N(TAG_N), .ROB_N(ROB_N)) u_dispatch (
      .clk            (clk)
    , .rst            (rst)
    , .inst_vld       (inst_vld)
    , .inst_op        (inst_op)
    , .inst_wa        (inst_wa)
    , .inst_ra0       (inst_ra0)
    , .inst_ra1       (inst_ra1)
    , .inst_imm       (inst_imm)
    , .inst_adv       (inst_adv)
    , .rs_full        (rs_full)
    , .tag_avail      (tag_avail)
    , .free_tag       (free_tag)
    , .rob_full       (rob_full)
    , .alloc_robid    (alloc_robid)
    , .src_busy       (src_busy)
    , .src_tag0       (src_tag0)
    , .src_tag1       (src_tag1)
    , .src_data0      (src_data0)
    , .src_data1      (src_data1)
    , .wa_busy        (wa_busy)
    , .cdb_vld        (cdb_vld)
    , .cdb_wa         (cdb_wa)
    , .cdb_wdata      (cdb_wdata)
    , .dis_fire       (dis_fire)
    , .dis_vld_r      (dis_vld_r)
    , .dis_op_r       (dis_op_r)
    , .dis_wa_r       (dis_wa_r)
    , .dis_tag_r      (dis_tag_r)
    , .dis_robid_r    (dis_robid_r)
    , .dis_imm_r      (dis_imm_r)
    , .dis_src_busy_r (dis_src_busy_r)
    , .dis_src0_r     (dis_src0_r)
    , .dis_src1_r     (dis_src1_r)
  );

  // Program order is restored here before the output port
  reorder_buffer #(.ROB_N(ROB_N)) u_rob (
      .clk         (clk)
    , .rst         (rst)
    , .alloc       (dis_fire)
    , .alloc_wa    (inst_wa)
    , .cmpl_vld    (cdb_vld)
    , .cmpl_id     (cdb_robid)
    , .cmpl_data   (cdb_wdata)
    , .alloc_robid (alloc_robid)
    , .rob_full    (rob_full)
    , .out_vld_r   (out_vld_r)
    , .out_wa_r    (out_wa_r)
    , .out_wdata_r (out_wdata_r)
  );

endmodule

`default_nettype wire

/* design/tomasulo_pkg.sv */
// Shared widths and opcode classes; opcode encodings must match the instruction source
`default_nettype none

package tomasulo_pkg;

  // Datapath and register file geometry
  localparam int WORD_W = 32;
  localparam int REG_N  = 32;
  localparam int REG_W  = 5;

  // Stations 0-1 arith, 2-3 logic, 4 multiply
  localparam int RS_N = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  reg_t;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_ADDI = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4,
    OP_MUL  = 3'd5
  } opcode_e;

  typedef enum logic [1:0] {
    UNIT_ARITH = 2'd0,
    UNIT_LOGIC = 2'd1,
    UNIT_MPY   = 2'd2
  } unit_e;

  // Execution unit class of an opcode
  function automatic unit_e unit_of(opcode_e op);
    case (op)
      OP_AND, OP_OR: return UNIT_LOGIC;
      OP_MUL:        return UNIT_MPY;
      default:       return UNIT_ARITH;
    endcase
  endfunction

  // Only ADDI replaces source 1 by its immediate
  function automatic logic uses_imm(opcode_e op);
    return op == OP_ADDI;
  endfunction

endpackage

`default_nettype wire

/* project.f */
+incdir+verification
design/tomasulo_pkg.sv
design/tag_free_list.sv
design/reg_state.sv
design/dispatch_ctrl.sv
design/reorder_buffer.sv
design/tomasulo_dispatcher.sv
verification/tb_clock.sv
verification/tb_top.sv

/* verification/tb_clock.sv */
// Free-running clock and power-on reset; reset drops at the edge that ends its last cycle
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 8
  , parameter int RST_CYCLES = 3
) (
    output logic clk
  , output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Nonblocking release so the DUT still sees reset on the last edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* verification/tb_tasks.svh */
// Directed tests included in tb_top; each starts and ends at a drive point with no work pending
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  // Empty machine takes tag 0, ROB slot 0 and station 0
  task automatic test_after_reset();
    logic [TAG_W-1:0]    tag;
    logic [ROB_W-1:0]    robid;
    tomasulo_pkg::word_t v;
    check_bits("dis_vld_r", dis_vld_r, '0);
    check_flag("out_vld_r", out_vld_r, 1'b0);
    drive_inst(tomasulo_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, '0);
    accept_and_check(5'b00001, 2'b00, '0, '0, tag, robid);
    check_tag("dis_tag_r", dis_tag_r, '0);
    check_robid("dis_robid_r", dis_robid_r, '0);
    rand_word(v);
    cdb_complete(5'd1, tag, robid, v);
    retire_check(5'd1, v);
  endtask

  // CDB write lands in the register, a later reader sees it settled
  task automatic test_retire();
    logic [TAG_W-1:0]    tag;
    logic [ROB_W-1:0]    robid;
    tomasulo_pkg::word_t imm;
    tomasulo_pkg::word_t v2;
    tomasulo_pkg::word_t v3;
    rand_word(imm);
    // ADDI source 1 reads as zero
    drive_inst(tomasulo_pkg::OP_ADDI, 5'd4, 5'd0, 5'd1, imm);
    accept_and_check(5'b00001, 2'b00, '0, '0, tag, robid);
    rand_word(v2);
    cdb_complete(5'd4, tag, robid, v2);
    retire_check(5'd4, v2);
    drive_inst(tomasulo_pkg::OP_ADD, 5'd8, 5'd4, 5'd4, '0);
    accept_and_check(5'b00001, 2'b00, v2, v2, tag, robid);
    rand_word(v3);
    cdb_complete(5'd8, tag, robid, v3);
    retire_check(5'd8, v3);
  endtask

  // Pending source carries its tag; a same-cycle CDB result bypasses
  task automatic test_bypass();
    logic [TAG_W-1:0]    p_tag;
    logic [ROB_W-1:0]    p_rob;
    logic [TAG_W-1:0]    m6_tag;
    logic [ROB_W-1:0]    m6_rob;
    logic [TAG_W-1:0]    m7_tag;
    logic [ROB_W-1:0]    m7_rob;
    tomasulo_pkg::word_t imm;
    tomasulo_pkg::word_t d;
    tomasulo_pkg::word_t e;
    tomasulo_pkg::word_t f;
    rand_word(imm);
    drive_inst(tomasulo_pkg::OP_ADDI, 5'd1, 5'd0, 5'd0, imm);
    accept_and_check(5'b00001, 2'b00, '0, '0, p_tag, p_rob);
    drive_inst(tomasulo_pkg::OP_MUL, 5'd6, 5'd1, 5'd0, '0);
    accept_and_check(5'b10000, 2'b01, tomasulo_pkg::word_t'(p_tag), '0, m6_tag, m6_rob);
    // Producer result on the bus in the dispatch cycle
    rand_word(d);
    drive_inst(tomasulo_pkg::OP_MUL, 5'd7, 5'd1, 5'd0, '0);
    drive_cdb(5'd1, p_tag, p_rob, d);
    accept_and_check(5'b10000, 2'b00, d, '0, m7_tag, m7_rob);
    retire_check(5'd1, d);
    rand_word(e);
    cdb_complete(5'd6, m6_tag, m6_rob, e);
    retire_check(5'd6, e);
    rand_word(f);
    cdb_complete(5'd7, m7_tag, m7_rob, f);
    retire_check(5'd7, f);
  endtask

  // Station masking, full-class stall and WAW stall
  task automatic test_stations();
    logic [TAG_W-1:0]    t_add;
    logic [TAG_W-1:0]    t_and;
    logic [TAG_W-1:0]    t_sub;
    logic [TAG_W-1:0]    t_or;
    logic [ROB_W-1:0]    r_add;
    logic [ROB_W-1:0]    r_and;
    logic [ROB_W-1:0]    r_sub;
    logic [ROB_W-1:0]    r_or;
    tomasulo_pkg::word_t va;
    tomasulo_pkg::word_t vb;
    tomasulo_pkg::word_t vc;
    tomasulo_pkg::word_t vd;
    rs_full = 5'b00001;
    drive_inst(tomasulo_pkg::OP_ADD, 5'd9, 5'd0, 5'd0, '0);
    accept_and_check(5'b00010, 2'b00, '0, '0, t_add, r_add);
    drive_inst(tomasulo_pkg::OP_AND, 5'd10, 5'd0, 5'd0, '0);
    accept_and_check(5'b00100, 2'b00, '0, '0, t_and, r_and);
    // Both arith stations full
    rs_full = 5'b00011;
    drive_inst(tomasulo_pkg::OP_SUB, 5'd11, 5'd0, 5'd0, '0);
    expect_stall(3);
    rs_full = 5'b00001;
    accept_and_check(5'b00010, 2'b00, '0, '0, t_sub, r_sub);
    // r9 still owned by the ADD
    drive_inst(tomasulo_pkg::OP_OR, 5'd9, 5'd0, 5'd0, '0);
    expect_stall(3);
    rand_word(va);
    cdb_complete(5'd9, t_add, r_add, va);
    accept_and_check(5'b00100, 2'b00, '0, '0, t_or, r_or);
    retire_check(5'd9, va);
    rand_word(vb);
    cdb_complete(5'd10, t_and, r_and, vb);
    retire_check(5'd10, vb);
    rand_word(vc);
    cdb_complete(5'd11, t_sub, r_sub, vc);
    retire_check(5'd11, vc);
    rand_word(vd);
    cdb_complete(5'd9, t_or, r_or, vd);
    retire_check(5'd9, vd);
    rs_full = '0;
  endtask

  // Reverse completion, retire still in dispatch order
  task automatic test_ooo_retire();
    logic [TAG_W-1:0]    tags [3];
    logic [ROB_W-1:0]    ids  [3];
    tomasulo_pkg::word_t vals [3];
    drive_inst(tomasulo_pkg::OP_ADD, 5'd12, 5'd0, 5'd0, '0);
    accept_and_check(5'b00001, 2'b00, '0, '0, tags[0], ids[0]);
    drive_inst(tomasulo_pkg::OP_SUB, 5'd13, 5'd0, 5'd0, '0);
    accept_and_check(5'b00001, 2'b00, '0, '0, tags[1], ids[1]);
    drive_inst(tomasulo_pkg::OP_OR, 5'd14, 5'd0, 5'd0, '0);
    accept_and_check(5'b00100, 2'b00, '0, '0, tags[2], ids[2]);
    for (int i = 2; i >= 0; i--) begin
      rand_word(vals[i]);
      cdb_complete(tomasulo_pkg::reg_t'(12 + i), tags[i], ids[i], vals[i]);
    end
    // Back-to-back pulses once the head is done
    retire_check(5'd12, vals[0]);
    next_cycle();
    retire_check(5'd13, vals[1]);
    next_cycle();
    retire_check(5'd14, vals[2]);
  endtask

  // ROB and tag pool both run dry, one retire reopens dispatch
  task automatic test_rob_full();
    logic [TAG_W-1:0]    tags [ROB_N+1];
    logic [ROB_W-1:0]    ids  [ROB_N+1];
    tomasulo_pkg::word_t vals [ROB_N+1];
    for (int i = 0; i < ROB_N; i++) begin
      drive_inst(tomasulo_pkg::OP_ADD, tomasulo_pkg::reg_t'(16 + i), 5'd0, 5'd0, '0);
      accept_and_check(5'b00001, 2'b00, '0, '0, tags[i], ids[i]);
    end
    drive_inst(tomasulo_pkg::OP_ADD, tomasulo_pkg::reg_t'(16 + ROB_N), 5'd0, 5'd0, '0);
    expect_stall(3);
    rand_word(vals[0]);
    cdb_complete(5'd16, tags[0], ids[0], vals[0]);
    // Tag is back but the ROB stays full until the head retires
    expect_stall(1);
    retire_check(5'd16, vals[0]);
    accept_and_check(5'b00001, 2'b00, '0, '0, tags[ROB_N], ids[ROB_N]);
    for (int i = 1; i <= ROB_N; i++) begin
      rand_word(vals[i]);
      cdb_complete(tomasulo_pkg::reg_t'(16 + i), tags[i], ids[i], vals[i]);
      retire_check(tomasulo_pkg::reg_t'(16 + i), vals[i]);
    end
  endtask

`endif

/* verification/tb_top.sv */
// Testbench top for the dispatch stage; inputs move 1 ns after the edge, stops at the first error
`timescale 1ns/10ps
`default_nettype none

module tb_top;

  localparam int TAG_N    = 8;
  localparam int ROB_N    = 8;
  localparam int TAG_W    = $clog2(TAG_N);
  localparam int ROB_W    = $clog2(ROB_N);
  localparam int RS_N     = tomasulo_pkg::RS_N;
  // Longest single wait in cycles
  localparam int WAIT_MAX = 40;

  logic                  clk;
  logic                  rst;
  logic                  inst_vld;
  tomasulo_pkg::opcode_e inst_op;
  tomasulo_pkg::reg_t    inst_wa;
  tomasulo_pkg::reg_t    inst_ra0;
  tomasulo_pkg::reg_t    inst_ra1;
  tomasulo_pkg::word_t   inst_imm;
  logic                  inst_adv;
  logic [RS_N-1:0]       rs_full;
  logic                  cdb_vld;
  tomasulo_pkg::reg_t    cdb_wa;
  logic [TAG_W-1:0]      cdb_tag;
  logic [ROB_W-1:0]      cdb_robid;
  tomasulo_pkg::word_t   cdb_wdata;
  logic [RS_N-1:0]       dis_vld_r;
  tomasulo_pkg::opcode_e dis_op_r;
  tomasulo_pkg::reg_t    dis_wa_r;
  logic [TAG_W-1:0]      dis_tag_r;
  logic [ROB_W-1:0]      dis_robid_r;
  tomasulo_pkg::word_t   dis_imm_r;
  logic [1:0]            dis_src_busy_r;
  tomasulo_pkg::word_t   dis_src0_r;
  tomasulo_pkg::word_t   dis_src1_r;
  logic                  out_vld_r;
  tomasulo_pkg::reg_t    out_wa_r;
  tomasulo_pkg::word_t   out_wdata_r;

  // Reference state: tags in use and next ROB slot
  logic [TAG_N-1:0]      tag_used;
  int                    rob_tail;
  logic [31:0]           lfsr_state;

  tb_clock #(.PERIOD_NS(8), .RST_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

  // Port names match the local signals one to one
  tomasulo_dispatcher #(.TAG_N(TAG_N), .ROB_N(ROB_N)) dut0 (.*);

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_word(input string name, input tomasulo_pkg::word_t got,
                            input tomasulo_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input tomasulo_pkg::reg_t got,
                           input tomasulo_pkg::reg_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_op(input string name, input tomasulo_pkg::opcode_e got,
                          input tomasulo_pkg::opcode_e exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bits(input string name, input logic [RS_N-1:0] got,
                            input logic [RS_N-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_busy(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                           input logic [TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_robid(input string name, input logic [ROB_W-1:0] got,
                             input logic [ROB_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Right-shifting Galois step
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hE000_0200) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic rand_word(output tomasulo_pkg::word_t w);
    w = '0;
    for (int i = 0; i < tomasulo_pkg::WORD_W; i++) begin
      w = {w[tomasulo_pkg::WORD_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Free list hands out the lowest unused tag
  function automatic logic [TAG_W-1:0] lowest_free(logic [TAG_N-1:0] used);
    for (int i = 0; i < TAG_N; i++) begin
      if (!used[i])
        return TAG_W'(i);
    end
    return '0;
  endfunction

  // Edge plus 1 ns; a CDB strobe lasts exactly one cycle
  task automatic next_cycle();
    if (cdb_vld)
      tag_used[cdb_tag] = 1'b0;
    @(posedge clk);
    #1;
    cdb_vld = 1'b0;
  endtask

  task automatic drive_inst(input tomasulo_pkg::opcode_e op, input tomasulo_pkg::reg_t wa,
                            input tomasulo_pkg::reg_t ra0, input tomasulo_pkg::reg_t ra1,
                            input tomasulo_pkg::word_t imm);
    inst_vld = 1'b1;
    inst_op  = op;
    inst_wa  = wa;
    inst_ra0 = ra0;
    inst_ra1 = ra1;
    inst_imm = imm;
  endtask

  task automatic drive_cdb(input tomasulo_pkg::reg_t wa, input logic [TAG_W-1:0] tag,
                           input logic [ROB_W-1:0] robid, input tomasulo_pkg::word_t data);
    cdb_vld   = 1'b1;
    cdb_wa    = wa;
    cdb_tag   = tag;
    cdb_robid = robid;
    cdb_wdata = data;
  endtask

  task automatic cdb_complete(input tomasulo_pkg::reg_t wa, input logic [TAG_W-1:0] tag,
                              input logic [ROB_W-1:0] robid, input tomasulo_pkg::word_t data);
    drive_cdb(wa, tag, robid, data);
    next_cycle();
  endtask

  // Waits for inst_adv, then checks the registered dispatch one cycle later
  task automatic accept_and_check(input logic [RS_N-1:0] exp_rs, input logic [1:0] exp_busy,
                                  input tomasulo_pkg::word_t exp_src0,
                                  input tomasulo_pkg::word_t exp_src1,
                                  output logic [TAG_W-1:0] tag, output logic [ROB_W-1:0] robid);
    int waited;
    waited = 0;
    // Mid-cycle sample of the combinational handshake
    #2;
    while (!inst_adv) begin
      if (waited == WAIT_MAX)
        report_timeout("inst_adv on a dispatch");
      waited++;
      next_cycle();
      #2;
    end
    tag   = lowest_free(tag_used);
    robid = ROB_W'(rob_tail);
    tag_used[tag] = 1'b1;
    rob_tail = (rob_tail + 1) % ROB_N;
    next_cycle();
    inst_vld = 1'b0;
    check_bits("dis_vld_r", dis_vld_r, exp_rs);
    check_op("dis_op_r", dis_op_r, inst_op);
    check_reg("dis_wa_r", dis_wa_r, inst_wa);
    check_tag("dis_tag_r", dis_tag_r, tag);
    check_robid("dis_robid_r", dis_robid_r, robid);
    check_word("dis_imm_r", dis_imm_r, inst_imm);
    check_busy("dis_src_busy_r", dis_src_busy_r, exp_busy);
    check_word("dis_src0_r", dis_src0_r, exp_src0);
    check_word("dis_src1_r", dis_src1_r, exp_src1);
  endtask

  // Held instruction must not be taken for n cycles
  task automatic expect_stall(input int n);
    for (int i = 0; i < n; i++) begin
      #2;
      check_flag("inst_adv", inst_adv, 1'b0);
      next_cycle();
    end
  endtask

  // Leaves the pulse in place, caller moves on
  task automatic retire_check(input tomasulo_pkg::reg_t wa, input tomasulo_pkg::word_t data);
    int waited;
    waited = 0;
    while (!out_vld_r) begin
      if (waited == WAIT_MAX)
        report_timeout("out_vld_r on a retire");
      waited++;
      next_cycle();
    end
    check_reg("out_wa_r", out_wa_r, wa);
    check_word("out_wdata_r", out_wdata_r, data);
  endtask

  `include "tb_tasks.svh"

  initial begin
    int waited;
    inst_vld   = 1'b0;
    inst_op    = tomasulo_pkg::OP_ADD;
    inst_wa    = '0;
    inst_ra0   = '0;
    inst_ra1   = '0;
    inst_imm   = '0;
    rs_full    = '0;
    cdb_vld    = 1'b0;
    cdb_wa     = '0;
    cdb_tag    = '0;
    cdb_robid  = '0;
    cdb_wdata  = '0;
    tag_used   = '0;
    rob_tail   = 0;
    lfsr_state = 32'd29;
    waited     = 0;
    next_cycle();
    while (rst) begin
      if (waited == WAIT_MAX)
        report_timeout("reset release");
      waited++;
      next_cycle();
    end
    test_after_reset();
    test_retire();
    test_bypass();
    test_stations();
    test_ooo_retire();
    test_rob_full();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
